// File: ddr_req_pkg.sv
package ddr_req_pkg;

    // ************************************************************
    // widths of the DDR2 FIFO interface
    // ************************************************************

    // address FIFO address field
    localparam int ADDR_W = 31;
    // write-data FIFO data and byte mask
    localparam int DATA_W = 128;
    localparam int MASK_W = 16;
    // each read command returns two 128-bit beats on the read-data FIFO
    localparam int BEATS_PER_READ = 2;

    // ************************************************************
    // opcodes and grant encodings
    // ************************************************************

    // address FIFO command field
    typedef enum logic [2:0] {
        CMD_WRITE = 3'd0,
        CMD_READ  = 3'd1
    } ddr_cmd_e;

    // which client owns the DDR FIFOs in the current cycle
    typedef enum logic [2:0] {
        ACC_NONE   = 3'd0,
        ACC_ICACHE = 3'd1,
        ACC_DCACHE = 3'd2,
        ACC_PIXEL  = 3'd3,
        ACC_FILLER = 3'd4
    } access_e;

    // ************************************************************
    // request bundles
    // ************************************************************

    // full read/write request, used by both caches and toward DDR
    typedef struct packed {
        ddr_cmd_e            cmd;
        logic [ADDR_W-1:0]   addr;
        logic                af_wr_en;
        logic [DATA_W-1:0]   wdf_data;
        logic [MASK_W-1:0]   wdf_mask;
        logic                wdf_wr_en;
    } ddr_req_t;

    // read-only request from the pixel feeder
    typedef struct packed {
        logic [ADDR_W-1:0]   addr;
        logic                af_wr_en;
    } rd_req_t;

    // write-only request from the color filler
    typedef struct packed {
        logic [ADDR_W-1:0]   addr;
        logic                af_wr_en;
        logic [DATA_W-1:0]   wdf_data;
        logic [MASK_W-1:0]   wdf_mask;
        logic                wdf_wr_en;
    } wr_req_t;

endpackage

// File: read_tag_tracker.sv
`timescale 1ns/1ps

module read_tag_tracker #(
    parameter int TAG_W = 11
) (
    input  logic             clk,
    input  logic             rst,
    // read accepted by the address FIFO on behalf of this cache
    input  logic             i_capture,
    input  logic [TAG_W-1:0] i_issue_num,
    // number of the read whose beats are coming back now
    input  logic [TAG_W-1:0] i_return_num,
    input  logic             i_rdf_valid,
    output logic             o_owns_return
);
    import ddr_req_pkg::*;

    // enough bits to hold BEATS_PER_READ itself
    localparam int CNT_W = $clog2(BEATS_PER_READ + 1);

    logic [TAG_W-1:0] read_num;
    logic [CNT_W-1:0] beats_left;

    // read number of the outstanding request
    // only meaningful while beats_left is nonzero
    always_ff @(posedge clk) begin
        if (i_capture) begin
            read_num <= i_issue_num;
        end
    end

    // remaining beats of the outstanding read
    always_ff @(posedge clk) begin
        if (rst) begin
            beats_left <= '0;
        end else if (i_capture) begin
            beats_left <= CNT_W'(BEATS_PER_READ);
        end else if (o_owns_return && i_rdf_valid) begin
            beats_left <= beats_left - CNT_W'(1);
        end
    end

    // current return belongs to us
    assign o_owns_return = (beats_left != '0) && (read_num == i_return_num);

endmodule

// File: read_return_router.sv
`timescale 1ns/1ps

module read_return_router #(
    parameter int TAG_W = 11
) (
    input  logic                 clk,
    input  logic                 rst,
    // grant and read acceptance from the arbiter
    input  ddr_req_pkg::access_e i_grant,
    input  logic                 i_read_issued,
    // read-data FIFO side
    input  logic                 i_rdf_valid,
    output logic                 o_rdf_rd_en,
    // client read enables
    input  logic                 i_icache_rdf_rd_en,
    input  logic                 i_dcache_rdf_rd_en,
    input  logic                 i_pixel_rdf_rd_en,
    // client read valids
    output logic                 o_icache_rdf_valid,
    output logic                 o_dcache_rdf_valid,
    output logic                 o_pixel_rdf_valid
);
    import ddr_req_pkg::*;

    // low bits of the beat counter select the beat within a read
    localparam int BEAT_W = $clog2(BEATS_PER_READ);

    logic [TAG_W-1:0]        issue_cnt;
    logic [TAG_W+BEAT_W-1:0] beat_cnt;
    logic [TAG_W-1:0]        return_num;
    logic                    icache_capture;
    logic                    dcache_capture;
    logic                    icache_owns;
    logic                    dcache_owns;

    // ************************************************************
    // read numbering
    // ************************************************************

    // every accepted read gets the next number, wraps freely
    always_ff @(posedge clk) begin
        if (rst) begin
            issue_cnt <= '0;
        end else if (i_read_issued) begin
            issue_cnt <= issue_cnt + TAG_W'(1);
        end
    end

    // every returned beat advances, BEATS_PER_READ beats per read
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt <= '0;
        end else if (i_rdf_valid) begin
            beat_cnt <= beat_cnt + (TAG_W + BEAT_W)'(1);
        end
    end

    // beat count divided by beats per read
    assign return_num = beat_cnt[TAG_W+BEAT_W-1:BEAT_W];

    assign icache_capture = i_read_issued && (i_grant == ACC_ICACHE);
    assign dcache_capture = i_read_issued && (i_grant == ACC_DCACHE);

    // one tracker per cache, pixel reads are untracked
    read_tag_tracker #(
        .TAG_W (TAG_W)
    ) u_icache_tag (
        .clk           (clk),
        .rst           (rst),
        .i_capture     (icache_capture),
        .i_issue_num   (issue_cnt),
        .i_return_num  (return_num),
        .i_rdf_valid   (i_rdf_valid),
        .o_owns_return (icache_owns)
    );

    read_tag_tracker #(
        .TAG_W (TAG_W)
    ) u_dcache_tag (
        .clk           (clk),
        .rst           (rst),
        .i_capture     (dcache_capture),
        .i_issue_num   (issue_cnt),
        .i_return_num  (return_num),
        .i_rdf_valid   (i_rdf_valid),
        .o_owns_return (dcache_owns)
    );

    // ************************************************************
    // return steering
    // ************************************************************

    // icache first, then dcache, everything else is pixel data
    assign o_rdf_rd_en = icache_owns ? i_icache_rdf_rd_en :
                         dcache_owns ? i_dcache_rdf_rd_en :
                                       i_pixel_rdf_rd_en;

    assign o_icache_rdf_valid = icache_owns && i_rdf_valid;
    assign o_dcache_rdf_valid = !icache_owns && dcache_owns && i_rdf_valid;
    assign o_pixel_rdf_valid  = !icache_owns && !dcache_owns && i_rdf_valid;

endmodule

// File: ddr_req_arbiter.sv
`timescale 1ns/1ps

module ddr_req_arbiter (
    input  logic                  clk,
    input  logic                  rst,
    // DDR FIFO back-pressure
    input  logic                  i_af_full,
    input  logic                  i_wdf_full,
    // client requests
    input  ddr_req_pkg::ddr_req_t i_icache_req,
    input  ddr_req_pkg::ddr_req_t i_dcache_req,
    input  ddr_req_pkg::rd_req_t  i_pixel_req,
    input  ddr_req_pkg::wr_req_t  i_filler_req,
    // merged request toward DDR
    output ddr_req_pkg::ddr_req_t o_ddr,
    output ddr_req_pkg::access_e  o_grant,
    output logic                  o_read_issued,
    // per-client full flags
    output logic                  o_icache_full,
    output logic                  o_dcache_full,
    output logic                  o_pixel_full,
    output logic                  o_filler_full
);
    import ddr_req_pkg::*;

    logic     fifo_ready;
    logic     filler_reserved;
    logic     icache_wants;
    logic     dcache_wants;
    logic     pixel_wants;
    logic     filler_wants;
    ddr_req_t sel_req;

    // both FIFOs must have room, cmd and data are written together
    assign fifo_ready = !i_af_full && !i_wdf_full;

    assign icache_wants = i_icache_req.af_wr_en || i_icache_req.wdf_wr_en;
    assign dcache_wants = i_dcache_req.af_wr_en || i_dcache_req.wdf_wr_en;
    assign pixel_wants  = i_pixel_req.af_wr_en;
    assign filler_wants = i_filler_req.af_wr_en || i_filler_req.wdf_wr_en;

    // ************************************************************
    // filler reservation
    // ************************************************************

    // set after the first data beat of a burst, cleared after the second
    // keeps higher priority clients from splitting a filler burst
    always_ff @(posedge clk) begin
        if (rst) begin
            filler_reserved <= 1'b0;
        end else if ((o_grant == ACC_FILLER) && i_filler_req.wdf_wr_en && fifo_ready) begin
            filler_reserved <= !filler_reserved;
        end
    end

    // ************************************************************
    // priority grant and request mux
    // ************************************************************

    always_comb begin
        // idle: icache fields pass through with strobes low
        o_grant           = ACC_NONE;
        sel_req           = i_icache_req;
        sel_req.af_wr_en  = 1'b0;
        sel_req.wdf_wr_en = 1'b0;

        if (icache_wants && !filler_reserved) begin
            o_grant = ACC_ICACHE;
            sel_req = i_icache_req;
        end else if (dcache_wants && !filler_reserved) begin
            o_grant = ACC_DCACHE;
            sel_req = i_dcache_req;
        end else if (pixel_wants && !filler_reserved) begin
            o_grant = ACC_PIXEL;
            // read-only path, no data is written
            sel_req.cmd       = CMD_READ;
            sel_req.addr      = i_pixel_req.addr;
            sel_req.af_wr_en  = i_pixel_req.af_wr_en;
            sel_req.wdf_data  = '0;
            sel_req.wdf_mask  = '1;
            sel_req.wdf_wr_en = 1'b0;
        end else if (filler_wants) begin
            o_grant = ACC_FILLER;
            // write-only path
            sel_req.cmd       = CMD_WRITE;
            sel_req.addr      = i_filler_req.addr;
            sel_req.af_wr_en  = i_filler_req.af_wr_en;
            sel_req.wdf_data  = i_filler_req.wdf_data;
            sel_req.wdf_mask  = i_filler_req.wdf_mask;
            sel_req.wdf_wr_en = i_filler_req.wdf_wr_en;
        end
    end

    // strobes only pass when both FIFOs can take them
    always_comb begin
        o_ddr           = sel_req;
        o_ddr.af_wr_en  = sel_req.af_wr_en && fifo_ready;
        o_ddr.wdf_wr_en = sel_req.wdf_wr_en && fifo_ready;
    end

    // read command actually accepted by the address FIFO
    assign o_read_issued = o_ddr.af_wr_en && (o_ddr.cmd == CMD_READ);

    // ************************************************************
    // full flags
    // ************************************************************

    // a client sees room only when granted and both FIFOs have space
    assign o_icache_full = !((o_grant == ACC_ICACHE) && fifo_ready);
    assign o_dcache_full = !((o_grant == ACC_DCACHE) && fifo_ready);
    assign o_pixel_full  = !((o_grant == ACC_PIXEL) && fifo_ready);
    assign o_filler_full = !((o_grant == ACC_FILLER) && fifo_ready);

endmodule

// File: ddr_request_ctrl.sv
`timescale 1ns/1ps

module ddr_request_ctrl #(
    parameter int TAG_W = 11
) (
    input  logic                  clk,
    input  logic                  rst,
    // DDR FIFO status
    input  logic                  i_af_full,
    input  logic                  i_wdf_full,
    input  logic                  i_rdf_valid,
    // DDR FIFO controls
    output ddr_req_pkg::ddr_req_t o_ddr,
    output logic                  o_rdf_rd_en,
    // client requests
    input  ddr_req_pkg::ddr_req_t i_icache_req,
    input  ddr_req_pkg::ddr_req_t i_dcache_req,
    input  ddr_req_pkg::rd_req_t  i_pixel_req,
    input  ddr_req_pkg::wr_req_t  i_filler_req,
    // client read enables
    input  logic                  i_icache_rdf_rd_en,
    input  logic                  i_dcache_rdf_rd_en,
    input  logic                  i_pixel_rdf_rd_en,
    // client full flags
    output logic                  o_icache_full,
    output logic                  o_dcache_full,
    output logic                  o_pixel_full,
    output logic                  o_filler_full,
    // client read valids
    output logic                  o_icache_rdf_valid,
    output logic                  o_dcache_rdf_valid,
    output logic                  o_pixel_rdf_valid
);
    import ddr_req_pkg::*;

    access_e grant;
    logic    read_issued;

    // request side, combinational priority mux
    ddr_req_arbiter u_arbiter (
        .clk           (clk),
        .rst           (rst),
        .i_af_full     (i_af_full),
        .i_wdf_full    (i_wdf_full),
        .i_icache_req  (i_icache_req),
        .i_dcache_req  (i_dcache_req),
        .i_pixel_req   (i_pixel_req),
        .i_filler_req  (i_filler_req),
        .o_ddr         (o_ddr),
        .o_grant       (grant),
        .o_read_issued (read_issued),
        .o_icache_full (o_icache_full),
        .o_dcache_full (o_dcache_full),
        .o_pixel_full  (o_pixel_full),
        .o_filler_full (o_filler_full)
    );

    // return side, steers read data by read number
    read_return_router #(
        .TAG_W (TAG_W)
    ) u_router (
        .clk                (clk),
        .rst                (rst),
        .i_grant            (grant),
        .i_read_issued      (read_issued),
        .i_rdf_valid        (i_rdf_valid),
        .o_rdf_rd_en        (o_rdf_rd_en),
        .i_icache_rdf_rd_en (i_icache_rdf_rd_en),
        .i_dcache_rdf_rd_en (i_dcache_rdf_rd_en),
        .i_pixel_rdf_rd_en  (i_pixel_rdf_rd_en),
        .o_icache_rdf_valid (o_icache_rdf_valid),
        .o_dcache_rdf_valid (o_dcache_rdf_valid),
        .o_pixel_rdf_valid  (o_pixel_rdf_valid)
    );

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD     = 4.0,
    parameter int  RST_CYCLES = 2
) (
    output logic o_clk,
    output logic o_rst
);

    // free running clock
    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2.0) o_clk = ~o_clk;
    end

    // reset held for a fixed number of rising edges, released on an edge
    initial begin
        o_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

// File: tb_ddr_request_ctrl.sv
`timescale 1ns/1ps

module tb_ddr_request_ctrl;
    import ddr_req_pkg::*;

    localparam int STIM_CYCLES    = 2000;
    // stimulus plus a quarter for reset, idle checks and the read drain
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + STIM_CYCLES / 4;

    logic     clk;
    logic     rst;
    logic     af_full, wdf_full, rdf_valid;
    ddr_req_t ddr;
    logic     rdf_rd_en;
    ddr_req_t icache_req, dcache_req;
    rd_req_t  pixel_req;
    wr_req_t  filler_req;
    logic     icache_rd_en, dcache_rd_en, pixel_rd_en;
    logic     icache_full, dcache_full, pixel_full, filler_full;
    logic     icache_valid, dcache_valid, pixel_valid;

    // reference model state
    logic       reserved;
    access_e    read_q[$];
    int         beat_cnt;
    // accepted this cycle, {icache, dcache, pixel, filler}
    logic [3:0] acc;
    integer     seed;
    int         errors;
    int         checks;
    int         cycles = 0;

    tb_clk_gen #(.PERIOD(4.0), .RST_CYCLES(2)) u_clk_gen (.o_clk(clk), .o_rst(rst));

    ddr_request_ctrl #(
        .TAG_W (11)
    ) u_dut (
        .clk                (clk),
        .rst                (rst),
        .i_af_full          (af_full),
        .i_wdf_full         (wdf_full),
        .i_rdf_valid        (rdf_valid),
        .o_ddr              (ddr),
        .o_rdf_rd_en        (rdf_rd_en),
        .i_icache_req       (icache_req),
        .i_dcache_req       (dcache_req),
        .i_pixel_req        (pixel_req),
        .i_filler_req       (filler_req),
        .i_icache_rdf_rd_en (icache_rd_en),
        .i_dcache_rdf_rd_en (dcache_rd_en),
        .i_pixel_rdf_rd_en  (pixel_rd_en),
        .o_icache_full      (icache_full),
        .o_dcache_full      (dcache_full),
        .o_pixel_full       (pixel_full),
        .o_filler_full      (filler_full),
        .o_icache_rdf_valid (icache_valid),
        .o_dcache_rdf_valid (dcache_valid),
        .o_pixel_rdf_valid  (pixel_valid)
    );

    // ************************************************************
    // compare tasks
    // ************************************************************

    task automatic check_req(input string name, input ddr_req_t got, input ddr_req_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_grant_full(input logic [3:0] got, input logic [3:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t full flags got %b expected %b", $time, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // ************************************************************
    // stimulus helpers
    // ************************************************************

    function automatic logic [DATA_W-1:0] rand_data();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // true while a read of this owner waits for its beats
    function automatic logic has_read(input access_e who);
        foreach (read_q[i]) begin
            if (read_q[i] == who)
                return 1'b1;
        end
        return 1'b0;
    endfunction

    // idle, read or write, fields always random so idle pass-through is visible
    task automatic make_cache_req(input logic read_ok, output ddr_req_t req);
        logic [1:0] kind;
        kind          = 2'($random(seed));
        req.cmd       = CMD_WRITE;
        req.addr      = ADDR_W'($random(seed));
        req.af_wr_en  = 1'b0;
        req.wdf_data  = rand_data();
        req.wdf_mask  = MASK_W'($random(seed));
        req.wdf_wr_en = 1'b0;
        if (kind == 2'd2 && read_ok) begin
            req.cmd      = CMD_READ;
            req.af_wr_en = 1'b1;
        end else if (kind == 2'd3) begin
            req.af_wr_en  = 1'b1;
            req.wdf_wr_en = 1'b1;
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        r            = $random(seed);
        af_full      = (r[1:0] == 2'd0);
        wdf_full     = (r[3:2] == 2'd0);
        // DDR only returns data for reads in flight
        rdf_valid    = (read_q.size() != 0) && (r[5:4] != 2'd0);
        icache_rd_en = r[6];
        dcache_rd_en = r[7];
        pixel_rd_en  = r[8];
        // each client holds its request until it is accepted
        if (!(icache_req.af_wr_en || icache_req.wdf_wr_en) || acc[3])
            make_cache_req(!has_read(ACC_ICACHE), icache_req);
        if (!(dcache_req.af_wr_en || dcache_req.wdf_wr_en) || acc[2])
            make_cache_req(!has_read(ACC_DCACHE), dcache_req);
        if (!pixel_req.af_wr_en || acc[1]) begin
            pixel_req.addr     = ADDR_W'($random(seed));
            pixel_req.af_wr_en = r[9];
        end
        if (!(filler_req.af_wr_en || filler_req.wdf_wr_en) || acc[0]) begin
            filler_req.addr      = ADDR_W'($random(seed));
            filler_req.wdf_data  = rand_data();
            filler_req.wdf_mask  = MASK_W'($random(seed));
            // first beat carries the command, second beat is data only
            filler_req.af_wr_en  = !reserved && (r[11:10] == 2'd0);
            filler_req.wdf_wr_en = reserved ? (r[12] || r[13]) : filler_req.af_wr_en;
        end
    endtask

    // ************************************************************
    // reference model, one call per cycle between edges
    // ************************************************************

    task automatic check_cycle();
        access_e    grant;
        access_e    owner;
        ddr_req_t   exp_ddr;
        logic       ready;
        logic [3:0] exp_full;
        logic       exp_rd_en;
        ready = !af_full && !wdf_full;
        // lowest priority first, higher clients override
        grant = ACC_NONE;
        if (filler_req.af_wr_en || filler_req.wdf_wr_en)
            grant = ACC_FILLER;
        if (!reserved && pixel_req.af_wr_en)
            grant = ACC_PIXEL;
        if (!reserved && (dcache_req.af_wr_en || dcache_req.wdf_wr_en))
            grant = ACC_DCACHE;
        if (!reserved && (icache_req.af_wr_en || icache_req.wdf_wr_en))
            grant = ACC_ICACHE;
        exp_ddr = icache_req;
        exp_ddr.af_wr_en  = 1'b0;
        exp_ddr.wdf_wr_en = 1'b0;
        case (grant)
            ACC_ICACHE: exp_ddr = icache_req;
            ACC_DCACHE: exp_ddr = dcache_req;
            ACC_PIXEL:  exp_ddr = {CMD_READ, pixel_req, {DATA_W{1'b0}}, {MASK_W{1'b1}}, 1'b0};
            ACC_FILLER: exp_ddr = {CMD_WRITE, filler_req};
            default: ;
        endcase
        exp_ddr.af_wr_en  = exp_ddr.af_wr_en && ready;
        exp_ddr.wdf_wr_en = exp_ddr.wdf_wr_en && ready;
        exp_full[3] = !(ready && grant == ACC_ICACHE);
        exp_full[2] = !(ready && grant == ACC_DCACHE);
        exp_full[1] = !(ready && grant == ACC_PIXEL);
        exp_full[0] = !(ready && grant == ACC_FILLER);
        // returns follow issue order, untracked data belongs to the pixel feeder
        owner     = (read_q.size() == 0) ? ACC_PIXEL : read_q[0];
        exp_rd_en = (owner == ACC_ICACHE) ? icache_rd_en :
                    (owner == ACC_DCACHE) ? dcache_rd_en : pixel_rd_en;
        check_req("o_ddr", ddr, exp_ddr);
        check_grant_full({icache_full, dcache_full, pixel_full, filler_full}, exp_full);
        check_bit("o_rdf_rd_en", rdf_rd_en, exp_rd_en);
        check_bit("o_icache_rdf_valid", icache_valid, rdf_valid && owner == ACC_ICACHE);
        check_bit("o_dcache_rdf_valid", dcache_valid, rdf_valid && owner == ACC_DCACHE);
        check_bit("o_pixel_rdf_valid", pixel_valid,
                  rdf_valid && owner != ACC_ICACHE && owner != ACC_DCACHE);
        acc = ~exp_full;
        if (!rst) begin
            // the beat retires against the old head before a new read joins
            if (rdf_valid && read_q.size() != 0) begin
                beat_cnt++;
                if (beat_cnt == BEATS_PER_READ) begin
                    read_q.delete(0);
                    beat_cnt = 0;
                end
            end
            if (exp_ddr.af_wr_en && exp_ddr.cmd == CMD_READ)
                read_q.push_back(grant);
            // burst half done on the first data beat, over on the second
            if (grant == ACC_FILLER && exp_ddr.wdf_wr_en)
                reserved = !reserved;
        end
    endtask

    // ************************************************************
    // run control
    // ************************************************************

    initial begin
        seed = 91281;
        errors = 0;
        checks = 0;
        reserved = 1'b0;
        beat_cnt = 0;
        acc = '0;
        af_full = 1'b0;
        wdf_full = 1'b0;
        rdf_valid = 1'b0;
        icache_rd_en = 1'b0;
        dcache_rd_en = 1'b0;
        pixel_rd_en = 1'b0;
        icache_req = '0;
        dcache_req = '0;
        pixel_req = '0;
        filler_req = '0;
        // beat with no read behind it, counters held by reset
        @(negedge clk);
        rdf_valid = 1'b1;
        #1;
        check_cycle();
        // idle after reset
        repeat (4) begin
            @(negedge clk);
            rdf_valid = 1'b0;
            #1;
            check_cycle();
        end
        repeat (STIM_CYCLES) begin
            @(negedge clk);
            drive_inputs();
            #1;
            check_cycle();
        end
        // stop requesting and let every outstanding read come back
        while (read_q.size() != 0) begin
            @(negedge clk);
            icache_req.af_wr_en = 1'b0;
            icache_req.wdf_wr_en = 1'b0;
            dcache_req.af_wr_en = 1'b0;
            dcache_req.wdf_wr_en = 1'b0;
            pixel_req.af_wr_en = 1'b0;
            filler_req.af_wr_en = 1'b0;
            filler_req.wdf_wr_en = 1'b0;
            rdf_valid = 1'b1;
            #1;
            check_cycle();
        end
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not end within %0d cycles, checks: %0d errors: %0d",
                     TIMEOUT_CYCLES, checks, errors);
            $display("CHECKS FAILED");
            $finish;
        end
    end

endmodule

// File: src.f
ddr_req_pkg.sv
read_tag_tracker.sv
read_return_router.sv
ddr_req_arbiter.sv
ddr_request_ctrl.sv
tb_clk_gen.sv
tb_ddr_request_ctrl.sv
